// ==== source/pc_profile_pkg.sv ====
`default_nettype none

package pc_profile_pkg;

  // word pc width and histogram geometry
  localparam int pc_width_lp = 12;
  localparam int bin_width_lp = 4;
  localparam int class_width_lp = 4;
  localparam int cause_width_lp = 4;
  localparam int hist_addr_width_lp = bin_width_lp + class_width_lp;
  localparam int hist_els_lp = 1 << hist_addr_width_lp;
  localparam int count_width_lp = 16;

  // one histogram column per class
  typedef enum logic [class_width_lp-1:0] {
    e_instr,
    e_fp_instr,
    e_icache_miss,
    e_stall_icache_store,
    e_stall_remote_ld_wb,
    e_stall_remote_flw_wb,
    e_stall_ifetch_wait,
    e_branch_miss,
    e_jalr_miss,
    e_icache_miss_bubble,
    e_stall_depend,
    e_stall_bypass,
    e_stall_fence,
    e_stall_remote_req,
    e_stall_busy,
    e_unknown
  } pc_class_e;

  // why execute holds no instruction
  typedef enum logic [cause_width_lp-1:0] {
    e_no_bubble,
    e_bub_branch_miss,
    e_bub_jalr_miss,
    e_bub_icache_miss,
    e_bub_depend,
    e_bub_bypass,
    e_bub_fence,
    e_bub_remote_req,
    e_bub_busy,
    e_bub_unknown
  } bubble_cause_e;

  typedef struct packed {
    logic exe_valid;
    logic exe_icache_miss;
    logic fp_exe_valid;
    logic branch_mispredict;
    logic jalr_mispredict;
    logic icache_miss_in_pipe;
  } pipe_status_s;

  typedef struct packed {
    logic stall_all;
    logic stall_id;
    // pipeline-wide sources
    logic icache_store;
    logic remote_ld_wb;
    logic remote_flw_wb;
    logic ifetch_wait;
    // id stage sources
    logic depend;
    logic bypass;
    logic fence;
    logic remote_req;
    logic busy;
  } stall_vec_s;

  typedef struct packed {
    bubble_cause_e cause;
    logic [pc_width_lp-1:0] pc;
  } exe_bubble_s;

  typedef struct packed {
    logic valid;
    pc_class_e ev_class;
    logic [pc_width_lp-1:0] pc;
  } pc_event_s;

endpackage

`default_nettype wire

// ==== source/pc_stage_tracker.sv ====
`timescale 1ns/10ps
`default_nettype none

module pc_stage_tracker (
  input  logic clk_i,
  input  logic reset_i,
  input  logic [pc_profile_pkg::pc_width_lp-1:0] id_pc_i,
  input  logic [pc_profile_pkg::pc_width_lp-1:0] exe_pc_i,
  input  pc_profile_pkg::pipe_status_s pipe_i,
  input  pc_profile_pkg::stall_vec_s stall_i,
  output logic [pc_profile_pkg::pc_width_lp-1:0] fp_exe_pc_o,
  output logic [pc_profile_pkg::pc_width_lp-1:0] mem_pc_o
);

  import pc_profile_pkg::*;

  logic [pc_width_lp-1:0] fp_exe_pc_r;
  logic [pc_width_lp-1:0] mem_pc_r;

  // fp stage trails id whenever id advances
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fp_exe_pc_r <= '0;
    end else if (~stall_i.stall_all & ~stall_i.stall_id) begin
      fp_exe_pc_r <= id_pc_i;
    end
  end

  // last valid instruction that left execute
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mem_pc_r <= '0;
    end else if (~stall_i.stall_all & pipe_i.exe_valid) begin
      mem_pc_r <= exe_pc_i;
    end
  end

  assign fp_exe_pc_o = fp_exe_pc_r;
  assign mem_pc_o = mem_pc_r;

endmodule

`default_nettype wire

// ==== source/exe_bubble_classifier.sv ====
`timescale 1ns/10ps
`default_nettype none

module exe_bubble_classifier (
  input  logic clk_i,
  input  logic reset_i,
  input  logic [pc_profile_pkg::pc_width_lp-1:0] id_pc_i,
  input  logic [pc_profile_pkg::pc_width_lp-1:0] exe_pc_i,
  input  pc_profile_pkg::pipe_status_s pipe_i,
  input  pc_profile_pkg::stall_vec_s stall_i,
  output pc_profile_pkg::exe_bubble_s bubble_o
);

  import pc_profile_pkg::*;

  exe_bubble_s bubble_r;
  exe_bubble_s bubble_n;

  // cause of the bubble entering execute on the next advance
  always_comb begin
    bubble_n.cause = e_no_bubble;
    bubble_n.pc = '0;
    if (pipe_i.branch_mispredict) begin
      bubble_n.cause = e_bub_branch_miss;
      bubble_n.pc = exe_pc_i;
    end else if (pipe_i.jalr_mispredict) begin
      bubble_n.cause = e_bub_jalr_miss;
      bubble_n.pc = exe_pc_i;
    end else if (stall_i.stall_id) begin
      bubble_n.pc = id_pc_i;
      // first id source wins
      if (stall_i.depend) begin
        bubble_n.cause = e_bub_depend;
      end else if (stall_i.bypass) begin
        bubble_n.cause = e_bub_bypass;
      end else if (stall_i.fence) begin
        bubble_n.cause = e_bub_fence;
      end else if (stall_i.remote_req) begin
        bubble_n.cause = e_bub_remote_req;
      end else if (stall_i.busy) begin
        bubble_n.cause = e_bub_busy;
      end else begin
        bubble_n.cause = e_bub_unknown;
      end
    end else if (pipe_i.icache_miss_in_pipe) begin
      bubble_n.cause = e_bub_icache_miss;
      bubble_n.pc = id_pc_i;
    end
  end

  // frozen along with the pipeline under stall_all
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bubble_r.cause <= e_no_bubble;
      bubble_r.pc <= '0;
    end else if (~stall_i.stall_all) begin
      bubble_r <= bubble_n;
    end
  end

  assign bubble_o = bubble_r;

endmodule

`default_nettype wire

// ==== source/pc_event_selector.sv ====
`timescale 1ns/10ps
`default_nettype none

module pc_event_selector (
  input  logic clk_i,
  input  logic reset_i,
  input  logic [pc_profile_pkg::pc_width_lp-1:0] exe_pc_i,
  input  logic [pc_profile_pkg::pc_width_lp-1:0] fp_exe_pc_i,
  input  logic [pc_profile_pkg::pc_width_lp-1:0] mem_pc_i,
  input  pc_profile_pkg::pipe_status_s pipe_i,
  input  pc_profile_pkg::stall_vec_s stall_i,
  input  pc_profile_pkg::exe_bubble_s bubble_i,
  output pc_profile_pkg::pc_event_s event_o
);

  import pc_profile_pkg::*;

  pc_event_s event_r;
  pc_event_s event_n;

  function automatic pc_class_e bubble_class(bubble_cause_e cause);
    pc_class_e cls;
    case (cause)
      e_bub_branch_miss: cls = e_branch_miss;
      e_bub_jalr_miss:   cls = e_jalr_miss;
      e_bub_icache_miss: cls = e_icache_miss_bubble;
      e_bub_depend:      cls = e_stall_depend;
      e_bub_bypass:      cls = e_stall_bypass;
      e_bub_fence:       cls = e_stall_fence;
      e_bub_remote_req:  cls = e_stall_remote_req;
      e_bub_busy:        cls = e_stall_busy;
      default:           cls = e_unknown;
    endcase
    return cls;
  endfunction

  // exactly one class per cycle, highest priority first
  always_comb begin
    event_n.valid = 1'b1;
    event_n.ev_class = e_unknown;
    event_n.pc = exe_pc_i;
    if (pipe_i.exe_valid & ~stall_i.stall_all & ~pipe_i.exe_icache_miss) begin
      event_n.ev_class = e_instr;
    end else if (pipe_i.fp_exe_valid & ~stall_i.stall_all) begin
      event_n.ev_class = e_fp_instr;
      event_n.pc = fp_exe_pc_i;
    end else if (pipe_i.exe_icache_miss) begin
      event_n.ev_class = e_icache_miss;
    end else if (stall_i.stall_all & stall_i.icache_store) begin
      event_n.ev_class = e_stall_icache_store;
    end else if (stall_i.stall_all & stall_i.remote_ld_wb) begin
      event_n.ev_class = e_stall_remote_ld_wb;
    end else if (stall_i.stall_all & stall_i.remote_flw_wb) begin
      event_n.ev_class = e_stall_remote_flw_wb;
    end else if (stall_i.stall_all & stall_i.ifetch_wait) begin
      // charged to the instruction waiting on the fetch
      event_n.ev_class = e_stall_ifetch_wait;
      event_n.pc = mem_pc_i;
    end else if (~pipe_i.exe_valid & (bubble_i.cause != e_no_bubble)) begin
      event_n.ev_class = bubble_class(bubble_i.cause);
      event_n.pc = bubble_i.pc;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      event_r <= '0;
    end else begin
      event_r <= event_n;
    end
  end

  assign event_o = event_r;

endmodule

`default_nettype wire

// ==== source/pc_histogram_table.sv ====
`timescale 1ns/10ps
`default_nettype none

module pc_histogram_table (
  input  logic clk_i,
  input  logic reset_i,
  input  pc_profile_pkg::pc_event_s event_i,
  input  logic clear_i,
  input  logic rd_en_i,
  input  logic [pc_profile_pkg::bin_width_lp-1:0] rd_bin_i,
  input  pc_profile_pkg::pc_class_e rd_class_i,
  output logic rd_valid_o,
  output logic [pc_profile_pkg::count_width_lp-1:0] rd_count_o
);

  import pc_profile_pkg::*;

  logic [count_width_lp-1:0] counts_r [hist_els_lp];

  logic [hist_addr_width_lp-1:0] inc_addr;
  logic [count_width_lp-1:0] inc_old;
  logic [count_width_lp-1:0] inc_new;
  logic [hist_addr_width_lp-1:0] rd_addr;
  logic rd_valid_r;
  logic [count_width_lp-1:0] rd_count_r;

  // address is bin then class
  assign inc_addr = {event_i.pc[bin_width_lp-1:0], event_i.ev_class};
  assign inc_old = counts_r[inc_addr];

  // stick at all ones
  assign inc_new = (inc_old == '1) ? inc_old : inc_old + 1'b1;

  always_ff @(posedge clk_i) begin
    if (reset_i | clear_i) begin
      for (int i = 0; i < hist_els_lp; i++) begin
        counts_r[i] <= '0;
      end
    end else if (event_i.valid) begin
      counts_r[inc_addr] <= inc_new;
    end
  end

  assign rd_addr = {rd_bin_i, rd_class_i};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_valid_r <= 1'b0;
    end else begin
      rd_valid_r <= rd_en_i;
    end
  end

  // sees the count before a same-cycle increment
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_count_r <= counts_r[rd_addr];
    end
  end

  assign rd_valid_o = rd_valid_r;
  assign rd_count_o = rd_count_r;

endmodule

`default_nettype wire

// ==== source/pc_profiler_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module pc_profiler_top (
  input  logic clk_i,
  input  logic reset_i,
  input  logic [pc_profile_pkg::pc_width_lp-1:0] id_pc_i,
  input  logic [pc_profile_pkg::pc_width_lp-1:0] exe_pc_i,
  input  pc_profile_pkg::pipe_status_s pipe_i,
  input  pc_profile_pkg::stall_vec_s stall_i,
  input  logic clear_i,
  input  logic rd_en_i,
  input  logic [pc_profile_pkg::bin_width_lp-1:0] rd_bin_i,
  input  pc_profile_pkg::pc_class_e rd_class_i,
  output logic rd_valid_o,
  output logic [pc_profile_pkg::count_width_lp-1:0] rd_count_o
);

  import pc_profile_pkg::*;

  logic [pc_width_lp-1:0] fp_exe_pc;
  logic [pc_width_lp-1:0] mem_pc;
  exe_bubble_s bubble;
  pc_event_s pc_event;

  pc_stage_tracker u_tracker (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .id_pc_i     (id_pc_i),
    .exe_pc_i    (exe_pc_i),
    .pipe_i      (pipe_i),
    .stall_i     (stall_i),
    .fp_exe_pc_o (fp_exe_pc),
    .mem_pc_o    (mem_pc)
  );

  exe_bubble_classifier u_classifier (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .id_pc_i  (id_pc_i),
    .exe_pc_i (exe_pc_i),
    .pipe_i   (pipe_i),
    .stall_i  (stall_i),
    .bubble_o (bubble)
  );

  pc_event_selector u_selector (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .exe_pc_i    (exe_pc_i),
    .fp_exe_pc_i (fp_exe_pc),
    .mem_pc_i    (mem_pc),
    .pipe_i      (pipe_i),
    .stall_i     (stall_i),
    .bubble_i    (bubble),
    .event_o     (pc_event)
  );

  pc_histogram_table u_table (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .event_i    (pc_event),
    .clear_i    (clear_i),
    .rd_en_i    (rd_en_i),
    .rd_bin_i   (rd_bin_i),
    .rd_class_i (rd_class_i),
    .rd_valid_o (rd_valid_o),
    .rd_count_o (rd_count_o)
  );

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // reset spans the first 8 rising edges
  initial begin
    reset_o = 1'b1;
    repeat (8) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== verification/pc_profiler_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module pc_profiler_tb;

  import pc_profile_pkg::*;

  logic clk_i;
  logic reset_i;
  logic [pc_width_lp-1:0] id_pc_i;
  logic [pc_width_lp-1:0] exe_pc_i;
  pipe_status_s pipe_i;
  stall_vec_s stall_i;
  logic clear_i;
  logic rd_en_i;
  logic [bin_width_lp-1:0] rd_bin_i;
  pc_class_e rd_class_i;
  logic rd_valid_o;
  logic [count_width_lp-1:0] rd_count_o;

  // reference model state
  logic [count_width_lp-1:0] exp_count [hist_els_lp];
  logic [pc_width_lp-1:0] m_fp_pc;
  logic [pc_width_lp-1:0] m_mem_pc;
  logic m_bub_valid;
  logic [3:0] m_bub_class;
  logic [pc_width_lp-1:0] m_bub_pc;
  logic pend_valid;
  logic [7:0] pend_addr;
  // expected value of the read in flight, and of the one being checked
  logic [count_width_lp-1:0] last_exp;
  logic [7:0] last_addr;
  logic [count_width_lp-1:0] chk_count;
  logic [7:0] chk_addr;
  int errors;
  int passed;
  int failed;
  int cycle_count;
  int cycle_limit;

  tb_clock_gen i_clk_gen (.clk_o(clk_i), .reset_o(reset_i));

  pc_profiler_top i_dut (.*);

  assert property (@(posedge clk_i) rd_valid_o |-> (rd_count_o == chk_count))
    else begin
      errors++;
      $display("CHECK FAILED rd_count_o bin %h class %h got %h exp %h",
               chk_addr[7:4], chk_addr[3:0], $sampled(rd_count_o), chk_count);
    end

  assert property (@(posedge clk_i) disable iff (reset_i) rd_en_i |=> rd_valid_o)
    else begin
      errors++;
      $display("rd_valid_o stayed low one cycle after a read request");
    end

  assert property (@(posedge clk_i) disable iff (reset_i) rd_valid_o |-> $past(rd_en_i))
    else begin
      errors++;
      $display("rd_valid_o went high without a read request in the cycle before");
    end

  assert property (@(posedge clk_i) reset_i |=> !rd_valid_o)
    else begin
      errors++;
      $display("rd_valid_o went high while reset was applied");
    end

  function automatic logic [3:0] id_stall_class(stall_vec_s s);
    if (s.depend) return e_stall_depend;
    if (s.bypass) return e_stall_bypass;
    if (s.fence) return e_stall_fence;
    if (s.remote_req) return e_stall_remote_req;
    if (s.busy) return e_stall_busy;
    return e_unknown;
  endfunction

  // class in the top nibble, responsible pc below
  function automatic logic [15:0] expected_event(pipe_status_s p, stall_vec_s s,
                                                 logic [pc_width_lp-1:0] xpc);
    logic [15:0] ev;
    if (p.exe_valid && !s.stall_all && !p.exe_icache_miss) ev = {e_instr, xpc};
    else if (p.fp_exe_valid && !s.stall_all) ev = {e_fp_instr, m_fp_pc};
    else if (p.exe_icache_miss) ev = {e_icache_miss, xpc};
    else if (s.stall_all && s.icache_store) ev = {e_stall_icache_store, xpc};
    else if (s.stall_all && s.remote_ld_wb) ev = {e_stall_remote_ld_wb, xpc};
    else if (s.stall_all && s.remote_flw_wb) ev = {e_stall_remote_flw_wb, xpc};
    else if (s.stall_all && s.ifetch_wait) ev = {e_stall_ifetch_wait, m_mem_pc};
    else if (!p.exe_valid && m_bub_valid) ev = {m_bub_class, m_bub_pc};
    else ev = {e_unknown, xpc};
    return ev;
  endfunction

  // one cycle from a falling edge to the next
  task automatic step(input pipe_status_s p, input stall_vec_s s,
                      input logic [pc_width_lp-1:0] ipc, input logic [pc_width_lp-1:0] xpc,
                      input logic rd, input logic [7:0] raddr, input logic clr);
    logic [15:0] ev;
    pipe_i = p;
    stall_i = s;
    id_pc_i = ipc;
    exe_pc_i = xpc;
    clear_i = clr;
    rd_en_i = rd;
    rd_bin_i = raddr[7:4];
    rd_class_i = pc_class_e'(raddr[3:0]);
    chk_count = last_exp;
    chk_addr = last_addr;
    if (rd) begin
      last_exp = exp_count[raddr];
      last_addr = raddr;
    end
    // counter write at the end of this cycle
    if (clr) begin
      foreach (exp_count[i])
        exp_count[i] = '0;
    end else if (pend_valid && exp_count[pend_addr] != '1) begin
      exp_count[pend_addr] = exp_count[pend_addr] + 16'd1;
    end
    ev = expected_event(p, s, xpc);
    pend_valid = 1'b1;
    pend_addr = {ev[3:0], ev[15:12]};
    if (!s.stall_all && !s.stall_id) m_fp_pc = ipc;
    if (!s.stall_all && p.exe_valid) m_mem_pc = xpc;
    if (!s.stall_all) begin
      m_bub_valid = 1'b1;
      m_bub_pc = (p.branch_mispredict || p.jalr_mispredict) ? xpc : ipc;
      if (p.branch_mispredict) m_bub_class = e_branch_miss;
      else if (p.jalr_mispredict) m_bub_class = e_jalr_miss;
      else if (s.stall_id) m_bub_class = id_stall_class(s);
      else if (p.icache_miss_in_pipe) m_bub_class = e_icache_miss_bubble;
      else m_bub_valid = 1'b0;
    end
    @(negedge clk_i);
  endtask

  task automatic drive(input pipe_status_s p, input stall_vec_s s,
                       input logic [pc_width_lp-1:0] ipc, input logic [pc_width_lp-1:0] xpc);
    step(p, s, ipc, xpc, 1'b0, 8'd0, 1'b0);
  endtask

  task automatic pulse_clear();
    step('0, '0, '0, '0, 1'b0, 8'd0, 1'b1);
  endtask

  // two idle cycles, then every bin and class
  task automatic readout();
    repeat (2) drive('0, '0, '0, '0);
    for (int a = 0; a < hist_els_lp; a++) begin
      step('0, '0, '0, '0, 1'b1, a[7:0], 1'b0);
    end
    drive('0, '0, '0, '0);
  endtask

  task automatic report_test(input string name, input int err_before);
    if (errors == err_before) begin
      passed++;
      $display("test %s passed", name);
    end else begin
      failed++;
      $display("test %s failed with %0d errors", name, errors - err_before);
    end
  endtask

  initial begin
    cycle_count = 0;
    cycle_limit = 20000;
    while (cycle_count < cycle_limit) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("run stopped by the cycle limit after %0d cycles", cycle_count);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    pipe_status_s p;
    stall_vec_s s;
    logic [31:0] r;
    logic [31:0] q;
    int e0;
    r = $urandom(32'h3ca57301);
    pipe_i = '0;
    stall_i = '0;
    id_pc_i = '0;
    exe_pc_i = '0;
    clear_i = 1'b0;
    rd_en_i = 1'b1;
    rd_bin_i = '0;
    rd_class_i = e_instr;
    foreach (exp_count[i])
      exp_count[i] = '0;
    m_fp_pc = '0;
    m_mem_pc = '0;
    m_bub_valid = 1'b0;
    m_bub_class = '0;
    m_bub_pc = '0;
    pend_valid = 1'b0;
    pend_addr = '0;
    last_exp = '0;
    last_addr = '0;
    chk_count = '0;
    chk_addr = '0;
    errors = 0;
    passed = 0;
    failed = 0;
    // read requests while reset is still held
    repeat (4) @(negedge clk_i);
    rd_en_i = 1'b0;
    do @(negedge clk_i); while (reset_i);

    e0 = errors;
    readout();
    p = '0;
    p.exe_valid = 1'b1;
    for (int i = 0; i < 50; i++) begin
      r = $urandom;
      drive(p, '0, r[23:12], r[11:0]);
    end
    pulse_clear();
    readout();
    report_test("reset_and_clear", e0);

    e0 = errors;
    pulse_clear();
    for (int i = 0; i < 300; i++) begin
      r = $urandom;
      p = '0;
      case (r[31:30])
        2'd0: p.fp_exe_valid = 1'b1;
        2'd1: p.exe_icache_miss = 1'b1;
        default: p.exe_valid = 1'b1;
      endcase
      drive(p, '0, r[23:12], r[11:0]);
    end
    readout();
    report_test("instr_attribution", e0);

    e0 = errors;
    pulse_clear();
    for (int i = 0; i < 300; i++) begin
      r = $urandom;
      p = '0;
      s = '0;
      p.exe_valid = r[25];
      s.stall_all = (r[31:30] != 2'd0);
      s[8:5] = r[29:26];
      drive(p, s, r[23:12], r[11:0]);
    end
    readout();
    report_test("pipeline_stalls", e0);

    e0 = errors;
    pulse_clear();
    for (int i = 0; i < 150; i++) begin
      r = $urandom;
      q = $urandom;
      p = '0;
      s = '0;
      p.exe_valid = 1'b1;
      case (r[31:29])
        3'd0: p.branch_mispredict = 1'b1;
        3'd1: p.jalr_mispredict = 1'b1;
        3'd2: p.icache_miss_in_pipe = 1'b1;
        3'd3: ;
        default: begin
          s.stall_id = 1'b1;
          s[4:0] = r[4:0];
        end
      endcase
      drive(p, s, r[23:12], q[11:0]);
      // the bubble reaches execute
      drive('0, '0, q[23:12], r[15:4]);
    end
    readout();
    report_test("bubble_causes", e0);

    e0 = errors;
    pulse_clear();
    for (int i = 0; i < 4000; i++) begin
      r = $urandom;
      q = $urandom;
      drive(r[5:0], r[16:6], q[11:0], q[23:12]);
    end
    readout();
    report_test("random_mix", e0);

    e0 = errors;
    cycle_limit = 90000;
    pulse_clear();
    p = '0;
    s = '0;
    s.stall_all = 1'b1;
    s.icache_store = 1'b1;
    repeat (65540) drive(p, s, 12'h000, 12'h5a7);
    readout();
    report_test("saturation", e0);

    $display("tests passed %0d failed %0d", passed, failed);
    if (failed == 0 && errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
source/pc_profile_pkg.sv
source/pc_stage_tracker.sv
source/exe_bubble_classifier.sv
source/pc_event_selector.sv
source/pc_histogram_table.sv
source/pc_profiler_top.sv
verification/tb_clock_gen.sv
verification/pc_profiler_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the profiler testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module pc_profiler_tb -f src.f -o sim_bin \
  || { echo "build failed"; exit 1; }

out="$(./obj_dir/sim_bin)"
echo "$out"

echo "$out" | grep -qx "Result: PASSED" && echo "simulation ok" \
  || { echo "simulation reported failure"; exit 1; }
